//--- sim.f
+incdir+testbench
verilog/tlb_pkg.sv
verilog/tlb_lookup_in.sv
verilog/tlb_entry_array.sv
verilog/tlb_match.sv
verilog/tlb_page_select.sv
verilog/tlb_top.sv
testbench/tb_tlb.sv

//--- Bender.yml
package:
  name: tlb_unit

sources:
  - files:
      - verilog/tlb_pkg.sv
      - verilog/tlb_lookup_in.sv
      - verilog/tlb_entry_array.sv
      - verilog/tlb_match.sv
      - verilog/tlb_page_select.sv
      - verilog/tlb_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_tlb.sv

//--- testbench/tb_tlb_model.svh
`ifndef TB_TLB_MODEL_SVH
`define TB_TLB_MODEL_SVH

// reference copy of the entry array
tlb_pkg::tlb_entry_t model_tlb [TLBNUM];
logic [TLBNUM-1:0]   model_written;

function automatic void model_reset();
    for (int i = 0; i < TLBNUM; i++) begin
        model_tlb[i] = '0;
    end
    model_written = '0;
endfunction

// 4 KB compares the full vppn, 2 MB only bits 18 to 9
function automatic logic model_va_hit(input tlb_pkg::tlb_entry_t ent,
                                      input logic [tlb_pkg::VPPN_W-1:0] vppn);
    if (ent.ps == tlb_pkg::PS_4K) begin
        return ent.vppn == vppn;
    end
    if (ent.ps == tlb_pkg::PS_2M) begin
        return ent.vppn[18:9] == vppn[18:9];
    end
    return 1'b0;
endfunction

function automatic void model_search(input tlb_pkg::tlb_search_req_t req,
                                     output tlb_pkg::tlb_search_rsp_t rsp,
                                     output logic [IDX_W-1:0] index);
    logic odd;

    rsp   = '0;
    index = '0;
    for (int i = 0; i < TLBNUM && !rsp.found; i++) begin
        if (model_tlb[i].e && (model_tlb[i].g || model_tlb[i].asid == req.asid) &&
            model_va_hit(model_tlb[i], req.vppn)) begin
            odd       = (model_tlb[i].ps == tlb_pkg::PS_4K) ? req.va_bit12 : req.vppn[8];
            rsp.found = 1'b1;
            rsp.ps    = model_tlb[i].ps;
            rsp.page  = odd ? model_tlb[i].page1 : model_tlb[i].page0;
            index     = IDX_W'(i);
        end
    end
endfunction

function automatic void model_write(input logic [IDX_W-1:0] index,
                                    input tlb_pkg::tlb_entry_t ent);
    model_tlb[index]     = ent;
    model_written[index] = 1'b1;
endfunction

function automatic void model_invalidate(input logic [tlb_pkg::INVTLB_OP_W-1:0] op,
                                         input logic [tlb_pkg::ASID_W-1:0] asid,
                                         input logic [tlb_pkg::VPPN_W-1:0] vppn);
    logic asid_eq;
    logic va_eq;
    logic kill;

    for (int i = 0; i < TLBNUM; i++) begin
        asid_eq = (model_tlb[i].asid == asid);
        va_eq   = model_va_hit(model_tlb[i], vppn);
        case (op)
            5'd0, 5'd1: kill = 1'b1;
            5'd2:       kill = model_tlb[i].g;
            5'd3:       kill = !model_tlb[i].g;
            5'd4:       kill = !model_tlb[i].g && asid_eq;
            5'd5:       kill = !model_tlb[i].g && asid_eq && va_eq;
            5'd6:       kill = (model_tlb[i].g || asid_eq) && va_eq;
            default:    kill = 1'b0;
        endcase
        if (kill) begin
            model_tlb[i].e = 1'b0;
        end
    end
endfunction

`endif

//--- testbench/tb_tlb.sv
`timescale 1ns/100ps

module tb_tlb;

    localparam int          TLBNUM     = 16;
    localparam int          IDX_W      = $clog2(TLBNUM);
    localparam int          MAX_CYCLES = 6000;
    localparam int          MIX_CYCLES = 3000;
    localparam logic [31:0] SEED       = 32'hdbc7674e;

    typedef struct packed {
        int                       due;
        logic [IDX_W-1:0]         index;
        tlb_pkg::tlb_search_rsp_t rsp;
    } exp_search_t;

    logic                            aclk;
    logic                            rst;
    logic                            s0_valid;
    tlb_pkg::tlb_search_req_t        s0_req;
    logic                            s1_valid;
    tlb_pkg::tlb_search_req_t        s1_req;
    logic                            invtlb_valid;
    logic [tlb_pkg::INVTLB_OP_W-1:0] invtlb_op;
    logic                            we;
    logic [IDX_W-1:0]                w_index;
    tlb_pkg::tlb_entry_t             w_entry;
    logic [IDX_W-1:0]                r_index;
    logic                            s0_rsp_valid;
    tlb_pkg::tlb_search_rsp_t        s0_rsp;
    logic [IDX_W-1:0]                s0_index;
    logic                            s1_rsp_valid;
    tlb_pkg::tlb_search_rsp_t        s1_rsp;
    logic [IDX_W-1:0]                s1_index;
    tlb_pkg::tlb_entry_t             r_entry;

    exp_search_t exp_q0[$];
    exp_search_t exp_q1[$];
    int          cyc = 0;
    int          checks = 0;
    int          errors = 0;
    int          test_errors = 0;

    `include "tb_tlb_model.svh"

    tlb_top #(
        .TLBNUM (TLBNUM)
    ) u_tlb_top (
        .aclk         (aclk),
        .rst          (rst),
        .s0_valid     (s0_valid),
        .s0_req       (s0_req),
        .s1_valid     (s1_valid),
        .s1_req       (s1_req),
        .invtlb_valid (invtlb_valid),
        .invtlb_op    (invtlb_op),
        .we           (we),
        .w_index      (w_index),
        .w_entry      (w_entry),
        .r_index      (r_index),
        .s0_rsp_valid (s0_rsp_valid),
        .s0_rsp       (s0_rsp),
        .s0_index     (s0_index),
        .s1_rsp_valid (s1_rsp_valid),
        .s1_rsp       (s1_rsp),
        .s1_index     (s1_index),
        .r_entry      (r_entry)
    );

    always #2 aclk = ~aclk;

    always @(posedge aclk) begin
        cyc <= cyc + 1;
        if (cyc >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cyc);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h, expected %h (cycle %0d)", name, got, exp, cyc);
        end
    endtask

    function automatic exp_search_t predict(input tlb_pkg::tlb_search_req_t req);
        exp_search_t exp;

        model_search(req, exp.rsp, exp.index);
        exp.due = cyc + 2;
        return exp;
    endfunction

    task automatic check_port(input int port, input logic valid,
                              input tlb_pkg::tlb_search_rsp_t rsp,
                              input logic [IDX_W-1:0] index);
        exp_search_t exp;
        int          pending;
        string       name;

        pending = (port == 0) ? exp_q0.size() : exp_q1.size();
        name    = (port == 0) ? "s0" : "s1";
        if (pending == 0) begin
            if (valid) begin
                errors++;
                $display("%s: response arrived with no search outstanding", name);
            end
            return;
        end
        exp = (port == 0) ? exp_q0[0] : exp_q1[0];
        if (valid || exp.due <= cyc) begin
            if (port == 0) begin
                void'(exp_q0.pop_front());
            end else begin
                void'(exp_q1.pop_front());
            end
            if (!valid) begin
                errors++;
                $display("%s: no response for the search due in cycle %0d", name, exp.due);
            end else begin
                if (exp.due != cyc) begin
                    errors++;
                    $display("%s: response in cycle %0d, due in cycle %0d", name, cyc, exp.due);
                end
                check({name, "_rsp"}, 128'(rsp), 128'(exp.rsp));
                check({name, "_index"}, 128'(index), 128'(exp.index));
            end
        end
    endtask

    // model step for one cycle and checks at the next falling edge
    task automatic tick();
        tlb_pkg::tlb_entry_t exp_read;
        logic                read_full;

        if (s0_valid) begin
            exp_q0.push_back(predict(s0_req));
        end
        if (s1_valid) begin
            exp_q1.push_back(predict(s1_req));
        end
        exp_read  = model_tlb[r_index];
        read_full = model_written[r_index];
        if (we) begin
            model_write(w_index, w_entry);
        end else if (invtlb_valid) begin
            model_invalidate(invtlb_op, s1_req.asid, s1_req.vppn);
        end
        @(negedge aclk);
        // fields other than e stay unknown until the first write
        if (read_full) begin
            check("r_entry", 128'(r_entry), 128'(exp_read));
        end else begin
            check("r_entry.e", 128'(r_entry.e), 128'(exp_read.e));
        end
        check_port(0, s0_rsp_valid, s0_rsp, s0_index);
        check_port(1, s1_rsp_valid, s1_rsp, s1_index);
        s0_valid     = 1'b0;
        s1_valid     = 1'b0;
        we           = 1'b0;
        invtlb_valid = 1'b0;
    endtask

    function automatic logic [tlb_pkg::PS_W-1:0] rand_ps();
        return ($urandom % 2) ? tlb_pkg::PS_4K : tlb_pkg::PS_2M;
    endfunction

    // small asid and vppn pools so that hits overlap
    function automatic tlb_pkg::tlb_entry_t rand_entry(input logic [tlb_pkg::PS_W-1:0] ps);
        logic [95:0]         raw;
        tlb_pkg::tlb_entry_t ent;

        raw      = {$urandom, $urandom, $urandom};
        ent      = raw[$bits(tlb_pkg::tlb_entry_t)-1:0];
        ent.e    = 1'b1;
        ent.ps   = ps;
        ent.asid = 10'($urandom % 4);
        ent.g    = ($urandom % 4) == 0;
        ent.vppn = {10'($urandom % 8), 9'($urandom % 4)};
        return ent;
    endfunction

    function automatic tlb_pkg::tlb_search_req_t req_for(input tlb_pkg::tlb_entry_t ent,
                                                         input logic bit12);
        tlb_pkg::tlb_search_req_t req;

        req.vppn = ent.vppn;
        if (ent.ps == tlb_pkg::PS_2M) begin
            req.vppn[8:0] = 9'($urandom);
        end
        req.va_bit12 = bit12;
        req.asid     = ent.asid;
        return req;
    endfunction

    function automatic tlb_pkg::tlb_search_req_t rand_req();
        if ($urandom % 4 == 0) begin
            return 30'($urandom);
        end
        return req_for(model_tlb[$urandom % TLBNUM], 1'($urandom));
    endfunction

    task automatic write_entry(input int idx, input tlb_pkg::tlb_entry_t ent);
        we      = 1'b1;
        w_index = IDX_W'(idx);
        w_entry = ent;
        r_index = IDX_W'(idx);
        tick();
    endtask

    task automatic search_pair(input tlb_pkg::tlb_search_req_t req0,
                               input tlb_pkg::tlb_search_req_t req1);
        s0_valid = 1'b1;
        s0_req   = req0;
        s1_valid = 1'b1;
        s1_req   = req1;
        tick();
    endtask

    // mode 0 is 4 KB, 1 is 2 MB, 2 mixes both
    task automatic fill_table(input int mode);
        for (int i = 0; i < TLBNUM; i++) begin
            if (mode == 0) begin
                write_entry(i, rand_entry(tlb_pkg::PS_4K));
            end else if (mode == 1) begin
                write_entry(i, rand_entry(tlb_pkg::PS_2M));
            end else begin
                write_entry(i, rand_entry(rand_ps()));
            end
        end
    endtask

    task automatic search_all();
        for (int i = 0; i < TLBNUM; i++) begin
            r_index = IDX_W'(i);
            search_pair(req_for(model_tlb[i], 1'b0), req_for(model_tlb[i], 1'b1));
        end
    endtask

    task automatic end_test(input string name);
        while (exp_q0.size() != 0 || exp_q1.size() != 0) begin
            tick();
        end
        $display("test %s done, %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    initial begin
        tlb_pkg::tlb_entry_t             ent;
        tlb_pkg::tlb_search_req_t        req;
        logic [tlb_pkg::INVTLB_OP_W-1:0] op;
        int                              k;

        void'($urandom(SEED));
        aclk         = 1'b0;
        rst          = 1'b1;
        s0_valid     = 1'b0;
        s0_req       = '0;
        s1_valid     = 1'b0;
        s1_req       = '0;
        invtlb_valid = 1'b0;
        invtlb_op    = '0;
        we           = 1'b0;
        w_index      = '0;
        w_entry      = '0;
        r_index      = '0;
        model_reset();
        repeat (16) @(posedge aclk);
        @(negedge aclk);
        rst = 1'b0;

        for (int i = 0; i < TLBNUM; i++) begin
            r_index = IDX_W'(i);
            tick();
        end
        end_test("read after reset");

        fill_table(0);
        search_all();
        end_test("4k search");

        fill_table(1);
        search_all();
        end_test("2m search");

        // empty table and then three entries on one vppn
        for (int i = 0; i < TLBNUM; i++) begin
            ent   = rand_entry(tlb_pkg::PS_4K);
            ent.e = 1'b0;
            write_entry(i, ent);
        end
        search_all();
        ent      = rand_entry(tlb_pkg::PS_4K);
        ent.asid = 10'd1;
        ent.g    = 1'b0;
        write_entry(9, ent);
        ent.g = 1'b1;
        write_entry(5, ent);
        ent.g = 1'b0;
        write_entry(2, ent);
        req = req_for(ent, 1'b0);
        search_pair(req, req);
        req.asid = 10'd2;
        search_pair(req, req);
        write_entry(5, ent);
        search_pair(req, req);
        end_test("asid, global and priority");

        for (int n = 0; n < 8; n++) begin
            op = (n < 7) ? 5'(n) : 5'd9;
            fill_table(2);
            k            = $urandom % TLBNUM;
            invtlb_valid = 1'b1;
            invtlb_op    = op;
            s1_req       = req_for(model_tlb[k], 1'b0);
            tick();
            search_all();
            end_test($sformatf("invtlb op %0d", op));
        end

        for (int n = 0; n < MIX_CYCLES; n++) begin
            r_index  = IDX_W'($urandom);
            s0_valid = ($urandom % 4) != 0;
            s0_req   = rand_req();
            s1_valid = ($urandom % 4) != 0;
            s1_req   = rand_req();
            k        = $urandom % 20;
            if (k < 2) begin
                we      = 1'b1;
                w_index = IDX_W'($urandom);
                w_entry = rand_entry(rand_ps());
            end else if (k == 2) begin
                invtlb_valid = 1'b1;
                invtlb_op    = 5'($urandom % 8);
            end
            tick();
        end
        end_test("random mix");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- verilog/tlb_top.sv
`timescale 1ns/100ps

module tlb_top #(
    parameter int TLBNUM = 16
) (
    input  logic                              aclk,
    input  logic                              rst,
    // search port 0, fetch
    input  logic                              s0_valid,
    input  tlb_pkg::tlb_search_req_t          s0_req,
    // search port 1, load/store and invtlb operands
    input  logic                              s1_valid,
    input  tlb_pkg::tlb_search_req_t          s1_req,
    input  logic                              invtlb_valid,
    input  logic [tlb_pkg::INVTLB_OP_W-1:0]   invtlb_op,
    // tlbwr / tlbfill
    input  logic                              we,
    input  logic [$clog2(TLBNUM)-1:0]         w_index,
    input  tlb_pkg::tlb_entry_t               w_entry,
    // tlbrd
    input  logic [$clog2(TLBNUM)-1:0]         r_index,
    output logic                              s0_rsp_valid,
    output tlb_pkg::tlb_search_rsp_t          s0_rsp,
    output logic [$clog2(TLBNUM)-1:0]         s0_index,
    output logic                              s1_rsp_valid,
    output tlb_pkg::tlb_search_rsp_t          s1_rsp,
    output logic [$clog2(TLBNUM)-1:0]         s1_index,
    output tlb_pkg::tlb_entry_t               r_entry
);

    logic                             s0_valid_q;
    tlb_pkg::tlb_search_req_t         s0_req_q;
    logic                             s1_valid_q;
    tlb_pkg::tlb_search_req_t         s1_req_q;
    tlb_pkg::tlb_inv_cmd_t            inv_cmd;
    logic                             we_q;
    logic [$clog2(TLBNUM)-1:0]        w_index_q;
    tlb_pkg::tlb_entry_t              w_entry_q;
    logic [$clog2(TLBNUM)-1:0]        r_index_q;

    tlb_pkg::tlb_entry_t [TLBNUM-1:0] entries;

    logic                             s0_hit;
    logic [$clog2(TLBNUM)-1:0]        s0_hit_index;
    tlb_pkg::tlb_entry_t              s0_hit_entry;
    logic                             s1_hit;
    logic [$clog2(TLBNUM)-1:0]        s1_hit_index;
    tlb_pkg::tlb_entry_t              s1_hit_entry;

    tlb_lookup_in #(
        .TLBNUM (TLBNUM)
    ) u_lookup_in (
        .aclk         (aclk),
        .rst          (rst),
        .s0_valid     (s0_valid),
        .s0_req       (s0_req),
        .s1_valid     (s1_valid),
        .s1_req       (s1_req),
        .invtlb_valid (invtlb_valid),
        .invtlb_op    (invtlb_op),
        .we           (we),
        .w_index      (w_index),
        .w_entry      (w_entry),
        .r_index      (r_index),
        .s0_valid_q   (s0_valid_q),
        .s0_req_q     (s0_req_q),
        .s1_valid_q   (s1_valid_q),
        .s1_req_q     (s1_req_q),
        .inv_cmd      (inv_cmd),
        .we_q         (we_q),
        .w_index_q    (w_index_q),
        .w_entry_q    (w_entry_q),
        .r_index_q    (r_index_q)
    );

    tlb_entry_array #(
        .TLBNUM (TLBNUM)
    ) u_entry_array (
        .aclk      (aclk),
        .rst       (rst),
        .inv_cmd   (inv_cmd),
        .we_q      (we_q),
        .w_index_q (w_index_q),
        .w_entry_q (w_entry_q),
        .r_index_q (r_index_q),
        .entries   (entries),
        .r_entry   (r_entry)
    );

    tlb_match #(
        .TLBNUM (TLBNUM)
    ) u_match0 (
        .req       (s0_req_q),
        .entries   (entries),
        .hit       (s0_hit),
        .hit_index (s0_hit_index),
        .hit_entry (s0_hit_entry)
    );

    tlb_match #(
        .TLBNUM (TLBNUM)
    ) u_match1 (
        .req       (s1_req_q),
        .entries   (entries),
        .hit       (s1_hit),
        .hit_index (s1_hit_index),
        .hit_entry (s1_hit_entry)
    );

    tlb_page_select #(
        .TLBNUM (TLBNUM)
    ) u_sel0 (
        .aclk      (aclk),
        .rst       (rst),
        .valid     (s0_valid_q),
        .req       (s0_req_q),
        .hit       (s0_hit),
        .hit_index (s0_hit_index),
        .hit_entry (s0_hit_entry),
        .rsp_valid (s0_rsp_valid),
        .rsp       (s0_rsp),
        .rsp_index (s0_index)
    );

    tlb_page_select #(
        .TLBNUM (TLBNUM)
    ) u_sel1 (
        .aclk      (aclk),
        .rst       (rst),
        .valid     (s1_valid_q),
        .req       (s1_req_q),
        .hit       (s1_hit),
        .hit_index (s1_hit_index),
        .hit_entry (s1_hit_entry),
        .rsp_valid (s1_rsp_valid),
        .rsp       (s1_rsp),
        .rsp_index (s1_index)
    );

endmodule

//--- verilog/tlb_page_select.sv
`timescale 1ns/100ps

module tlb_page_select #(
    parameter int TLBNUM = 16
) (
    input  logic                        aclk,
    input  logic                        rst,
    input  logic                        valid,
    input  tlb_pkg::tlb_search_req_t    req,
    input  logic                        hit,
    input  logic [$clog2(TLBNUM)-1:0]   hit_index,
    input  tlb_pkg::tlb_entry_t         hit_entry,
    output logic                        rsp_valid,
    output tlb_pkg::tlb_search_rsp_t    rsp,
    output logic [$clog2(TLBNUM)-1:0]   rsp_index
);

    logic                     odd;
    tlb_pkg::tlb_search_rsp_t rsp_d;

    // 2 MB pairs split on vppn bit 8, 4 KB pairs on va bit 12
    assign odd = (hit_entry.ps == tlb_pkg::PS_2M) ? req.vppn[8] : req.va_bit12;

    always_comb begin
        rsp_d = '0;
        if (hit) begin
            rsp_d.found = 1'b1;
            rsp_d.ps    = hit_entry.ps;
            rsp_d.page  = odd ? hit_entry.page1 : hit_entry.page0;
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= valid;
        end
    end

    // hit_index is already zero on a miss
    always_ff @(posedge aclk) begin
        rsp       <= rsp_d;
        rsp_index <= hit_index;
    end

endmodule

//--- verilog/tlb_match.sv
`timescale 1ns/100ps

module tlb_match #(
    parameter int TLBNUM = 16
) (
    input  tlb_pkg::tlb_search_req_t            req,
    input  tlb_pkg::tlb_entry_t [TLBNUM-1:0]    entries,
    output logic                                hit,
    output logic [$clog2(TLBNUM)-1:0]           hit_index,
    output tlb_pkg::tlb_entry_t                 hit_entry
);

    localparam int IDX_W = $clog2(TLBNUM);

    logic [TLBNUM-1:0] hit_vec;

    for (genvar i = 0; i < TLBNUM; i++) begin : g_cmp
        logic asid_ok;
        logic vppn_ok;

        assign asid_ok = entries[i].g || (entries[i].asid == req.asid);
        assign vppn_ok = tlb_pkg::vppn_match(entries[i].vppn, entries[i].ps, req.vppn);

        assign hit_vec[i] = entries[i].e && asid_ok && vppn_ok;
    end

    // downward scan leaves the lowest hit standing
    always_comb begin
        hit_index = '0;
        hit_entry = '0;
        for (int i = TLBNUM - 1; i >= 0; i--) begin
            if (hit_vec[i]) begin
                hit_index = IDX_W'(i);
                hit_entry = entries[i];
            end
        end
    end

    assign hit = |hit_vec;

endmodule

//--- verilog/tlb_entry_array.sv
`timescale 1ns/100ps

module tlb_entry_array #(
    parameter int TLBNUM = 16
) (
    input  logic                                aclk,
    input  logic                                rst,
    input  tlb_pkg::tlb_inv_cmd_t               inv_cmd,
    input  logic                                we_q,
    input  logic [$clog2(TLBNUM)-1:0]           w_index_q,
    input  tlb_pkg::tlb_entry_t                 w_entry_q,
    input  logic [$clog2(TLBNUM)-1:0]           r_index_q,
    output tlb_pkg::tlb_entry_t [TLBNUM-1:0]    entries,
    output tlb_pkg::tlb_entry_t                 r_entry
);

    localparam int IDX_W = $clog2(TLBNUM);

    tlb_pkg::tlb_entry_t [TLBNUM-1:0] entry_q;
    logic [TLBNUM-1:0]                inv_hit;

    // per-entry invalidate conditions
    for (genvar i = 0; i < TLBNUM; i++) begin : g_inv
        logic asid_ok;
        logic va_ok;
        logic scope_ok;

        assign asid_ok = !inv_cmd.use_asid || (entry_q[i].asid == inv_cmd.asid);

        assign va_ok = !inv_cmd.use_va ||
                       tlb_pkg::vppn_match(entry_q[i].vppn, entry_q[i].ps, inv_cmd.vppn);

        // g entries go by clear_g alone, the rest also need the asid
        assign scope_ok = entry_q[i].g ? inv_cmd.clear_g
                                       : (inv_cmd.clear_nong && asid_ok);

        assign inv_hit[i] = inv_cmd.valid && scope_ok && va_ok;
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            for (int i = 0; i < TLBNUM; i++) begin
                entry_q[i].e <= 1'b0;
            end
        end else begin
            for (int i = 0; i < TLBNUM; i++) begin
                // a write to this slot wins over an invalidate
                if (we_q && (w_index_q == IDX_W'(i))) begin
                    entry_q[i] <= w_entry_q;
                end else if (inv_hit[i]) begin
                    entry_q[i].e <= 1'b0;
                end
            end
        end
    end

    assign entries = entry_q;

    // read shows the array before this cycle's update
    assign r_entry = entry_q[r_index_q];

endmodule

//--- verilog/tlb_lookup_in.sv
`timescale 1ns/100ps

module tlb_lookup_in #(
    parameter int TLBNUM = 16
) (
    input  logic                              aclk,
    input  logic                              rst,
    input  logic                              s0_valid,
    input  tlb_pkg::tlb_search_req_t          s0_req,
    input  logic                              s1_valid,
    input  tlb_pkg::tlb_search_req_t          s1_req,
    input  logic                              invtlb_valid,
    input  logic [tlb_pkg::INVTLB_OP_W-1:0]   invtlb_op,
    input  logic                              we,
    input  logic [$clog2(TLBNUM)-1:0]         w_index,
    input  tlb_pkg::tlb_entry_t               w_entry,
    input  logic [$clog2(TLBNUM)-1:0]         r_index,
    output logic                              s0_valid_q,
    output tlb_pkg::tlb_search_req_t          s0_req_q,
    output logic                              s1_valid_q,
    output tlb_pkg::tlb_search_req_t          s1_req_q,
    output tlb_pkg::tlb_inv_cmd_t             inv_cmd,
    output logic                              we_q,
    output logic [$clog2(TLBNUM)-1:0]         w_index_q,
    output tlb_pkg::tlb_entry_t               w_entry_q,
    output logic [$clog2(TLBNUM)-1:0]         r_index_q
);

    tlb_pkg::tlb_inv_cmd_t inv_dec;

    // opcode to clear conditions
    always_comb begin
        inv_dec      = '0;
        // asid and vppn ride on port 1
        inv_dec.asid = s1_req.asid;
        inv_dec.vppn = s1_req.vppn;
        case (invtlb_op)
            tlb_pkg::INVTLB_ALL0, tlb_pkg::INVTLB_ALL1: begin
                inv_dec.valid      = invtlb_valid;
                inv_dec.clear_g    = 1'b1;
                inv_dec.clear_nong = 1'b1;
            end
            tlb_pkg::INVTLB_G: begin
                inv_dec.valid   = invtlb_valid;
                inv_dec.clear_g = 1'b1;
            end
            tlb_pkg::INVTLB_NONG: begin
                inv_dec.valid      = invtlb_valid;
                inv_dec.clear_nong = 1'b1;
            end
            tlb_pkg::INVTLB_NONG_ASID: begin
                inv_dec.valid      = invtlb_valid;
                inv_dec.clear_nong = 1'b1;
                inv_dec.use_asid   = 1'b1;
            end
            tlb_pkg::INVTLB_NONG_ASID_VA: begin
                inv_dec.valid      = invtlb_valid;
                inv_dec.clear_nong = 1'b1;
                inv_dec.use_asid   = 1'b1;
                inv_dec.use_va     = 1'b1;
            end
            tlb_pkg::INVTLB_G_OR_ASID_VA: begin
                // global entries skip the asid check
                inv_dec.valid      = invtlb_valid;
                inv_dec.clear_g    = 1'b1;
                inv_dec.clear_nong = 1'b1;
                inv_dec.use_asid   = 1'b1;
                inv_dec.use_va     = 1'b1;
            end
            default: begin
                inv_dec.valid = 1'b0;
            end
        endcase
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            s0_valid_q <= 1'b0;
            s1_valid_q <= 1'b0;
            we_q       <= 1'b0;
            inv_cmd    <= '0;
        end else begin
            s0_valid_q <= s0_valid;
            s1_valid_q <= s1_valid;
            we_q       <= we;
            inv_cmd    <= inv_dec;
        end
    end

    always_ff @(posedge aclk) begin
        s0_req_q  <= s0_req;
        s1_req_q  <= s1_req;
        w_index_q <= w_index;
        w_entry_q <= w_entry;
        r_index_q <= r_index;
    end

endmodule

//--- verilog/tlb_pkg.sv
package tlb_pkg;

    localparam int VPPN_W      = 19;
    localparam int ASID_W      = 10;
    localparam int PPN_W       = 20;
    localparam int PS_W        = 6;
    localparam int INVTLB_OP_W = 5;

    localparam logic [PS_W-1:0] PS_4K = 6'd12;
    localparam logic [PS_W-1:0] PS_2M = 6'd21;

    // invtlb operation codes
    localparam logic [INVTLB_OP_W-1:0] INVTLB_ALL0         = 5'd0;
    localparam logic [INVTLB_OP_W-1:0] INVTLB_ALL1         = 5'd1;
    localparam logic [INVTLB_OP_W-1:0] INVTLB_G            = 5'd2;
    localparam logic [INVTLB_OP_W-1:0] INVTLB_NONG         = 5'd3;
    localparam logic [INVTLB_OP_W-1:0] INVTLB_NONG_ASID    = 5'd4;
    localparam logic [INVTLB_OP_W-1:0] INVTLB_NONG_ASID_VA = 5'd5;
    localparam logic [INVTLB_OP_W-1:0] INVTLB_G_OR_ASID_VA = 5'd6;

    typedef struct packed {
        logic [PPN_W-1:0] ppn;
        logic [1:0]       plv;
        logic [1:0]       mat;
        logic             d;
        logic             v;
    } tlb_page_t;

    typedef struct packed {
        logic              e;
        logic [VPPN_W-1:0] vppn;
        logic [PS_W-1:0]   ps;
        logic [ASID_W-1:0] asid;
        logic              g;
        tlb_page_t         page0;
        tlb_page_t         page1;
    } tlb_entry_t;

    typedef struct packed {
        logic [VPPN_W-1:0] vppn;
        logic              va_bit12;
        logic [ASID_W-1:0] asid;
    } tlb_search_req_t;

    typedef struct packed {
        logic            found;
        logic [PS_W-1:0] ps;
        tlb_page_t       page;
    } tlb_search_rsp_t;

    typedef struct packed {
        logic              valid;
        logic              clear_g;
        logic              clear_nong;
        logic              use_asid;
        logic              use_va;
        logic [ASID_W-1:0] asid;
        logic [VPPN_W-1:0] vppn;
    } tlb_inv_cmd_t;

    // vppn compare with page-size masking
    function automatic logic vppn_match(
        input logic [VPPN_W-1:0] entry_vppn,
        input logic [PS_W-1:0]   entry_ps,
        input logic [VPPN_W-1:0] vppn
    );
        logic match;

        if (entry_ps == PS_4K) begin
            match = (entry_vppn == vppn);
        end else if (entry_ps == PS_2M) begin
            // low 9 bits lie inside the 2 MB page pair
            match = (entry_vppn[VPPN_W-1:9] == vppn[VPPN_W-1:9]);
        end else begin
            // unknown sizes never match
            match = 1'b0;
        end
        return match;
    endfunction

endpackage
